// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing
TOP       := tb_core
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/alu.sv ====
`timescale 1ns/100ps

module alu (
  input  core_pkg::alu_op_e i_op,
  input  logic [31:0]       i_a,
  input  logic [31:0]       i_b,
  output logic [31:0]       o_result,
  output logic              o_zero
);
  import core_pkg::*;

  logic [4:0] shamt;

  // shifts only look at the low five bits
  assign shamt = i_b[4:0];

  always_comb begin
    case (i_op)
      alu_add:  o_result = i_a + i_b;
      alu_sub:  o_result = i_a - i_b;
      alu_and:  o_result = i_a & i_b;
      alu_or:   o_result = i_a | i_b;
      alu_xor:  o_result = i_a ^ i_b;
      alu_slt:  o_result = {31'b0, $signed(i_a) < $signed(i_b)};
      alu_sltu: o_result = {31'b0, i_a < i_b};
      alu_sll:  o_result = i_a << shamt;
      alu_srl:  o_result = i_a >> shamt;
      alu_sra:  o_result = $unsigned($signed(i_a) >>> shamt);
      default:  o_result = '0;
    endcase
  end

  // branches compare with a subtract
  assign o_zero = (o_result == 32'd0);

endmodule

// ==== design/controller.sv ====
`timescale 1ns/100ps

module controller (
  input  logic [31:0]     i_inst,
  output core_pkg::ctrl_t o_ctrl
);
  import core_pkg::*;

  opcode_e    opc;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       op_ok;
  logic       imm_ok;

  assign opc    = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // funct7 only matters for sub and the arithmetic shift
  assign op_ok  = (funct7 == 7'b0000000) ||
                  ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
  assign imm_ok = ((funct3 != 3'b001) && (funct3 != 3'b101)) || (funct7 == 7'b0000000) ||
                  ((funct3 == 3'b101) && (funct7 == 7'b0100000));

  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    o_ctrl = '0;
    case (opc)
      opc_op: begin
        if (op_ok) begin
          o_ctrl.alu_op    = alu_decode(funct3, funct7[5]);
          o_ctrl.reg_write = 1'b1;
          o_ctrl.use_rs2   = 1'b1;
        end
      end
      opc_op_imm: begin
        // addi never subtracts, bit 30 is part of the immediate
        if (imm_ok) begin
          o_ctrl.alu_op      = alu_decode(funct3, (funct3 == 3'b101) && funct7[5]);
          o_ctrl.alu_src_imm = 1'b1;
          o_ctrl.imm_kind    = imm_i;
          o_ctrl.reg_write   = 1'b1;
        end
      end
      opc_lui: begin
        o_ctrl.alu_src_imm = 1'b1;
        o_ctrl.imm_kind    = imm_u;
        o_ctrl.reg_write   = 1'b1;
      end
      opc_load: begin
        if (funct3 == 3'b010) begin
          o_ctrl.alu_src_imm = 1'b1;
          o_ctrl.reg_write   = 1'b1;
          o_ctrl.mem_read    = 1'b1;
          o_ctrl.result_src  = res_mem;
        end
      end
      opc_store: begin
        if (funct3 == 3'b010) begin
          o_ctrl.alu_src_imm = 1'b1;
          o_ctrl.imm_kind    = imm_s;
          o_ctrl.mem_write   = 1'b1;
          o_ctrl.use_rs2     = 1'b1;
        end
      end
      opc_branch: begin
        // beq and bne only
        if (funct3[2:1] == 2'b00) begin
          o_ctrl.alu_op    = alu_sub;
          o_ctrl.imm_kind  = imm_b;
          o_ctrl.branch    = 1'b1;
          o_ctrl.branch_ne = funct3[0];
          o_ctrl.use_rs2   = 1'b1;
        end
      end
      opc_jal: begin
        o_ctrl.imm_kind   = imm_j;
        o_ctrl.jump       = 1'b1;
        o_ctrl.reg_write  = 1'b1;
        o_ctrl.result_src = res_pc4;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== design/core_pkg.sv ====
package core_pkg;

  // first fetch address after reset
  localparam logic [31:0] RESET_PC = 32'h0001_0000;

  // forwarding selects for the execute operands
  localparam logic [1:0] FWD_NONE = 2'd0;
  localparam logic [1:0] FWD_MEM  = 2'd1;
  localparam logic [1:0] FWD_WB   = 2'd2;

  // RV32I major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
  } alu_op_e;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_kind_e;

  typedef enum logic [1:0] {res_alu, res_pc4, res_mem} result_src_e;

  // all zero is a bubble
  typedef struct packed {
    alu_op_e     alu_op;
    logic        alu_src_imm;
    imm_kind_e   imm_kind;
    logic        reg_write;
    logic        mem_write;
    logic        mem_read;
    logic        branch;
    logic        branch_ne;
    logic        jump;
    result_src_e result_src;
    logic        use_rs2;
  } ctrl_t;

  typedef struct packed {
    logic [4:0] d_rs1;
    logic [4:0] d_rs2;
    logic       d_jump;
    logic       d_use_rs2;
    logic [4:0] e_rs1;
    logic [4:0] e_rs2;
    logic [4:0] e_rd;
    logic       e_mem_read;
    logic       e_branch_taken;
    logic [4:0] m_rd;
    logic       m_reg_write;
    logic [4:0] w_rd;
    logic       w_reg_write;
  } hazard_view_t;

  typedef struct packed {
    logic       stall_f;
    logic       stall_d;
    logic       flush_d;
    logic       flush_e;
    logic [1:0] fwd_a;
    logic [1:0] fwd_b;
  } hazard_ctrl_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
  } dmem_req_t;

endpackage

// ==== design/core_top.sv ====
`timescale 1ns/100ps

module core_top (
  input  logic                clk,
  input  logic                i_reset,
  input  logic [31:0]         i_inst,
  input  logic [31:0]         i_dmem_rdata,
  output logic [31:0]         o_pc,
  output core_pkg::dmem_req_t o_dmem,
  output logic                o_retire
);
  import core_pkg::*;

  logic [31:0]  d_inst;
  ctrl_t        d_ctrl;
  hazard_view_t view;
  hazard_ctrl_t hz;

  datapath u_datapath (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_inst       (i_inst),
    .i_dmem_rdata (i_dmem_rdata),
    .i_ctrl       (d_ctrl),
    .i_hz         (hz),
    .o_pc         (o_pc),
    .o_d_inst     (d_inst),
    .o_dmem       (o_dmem),
    .o_view       (view),
    .o_retire     (o_retire)
  );

  // decodes whatever sits in the decode stage
  controller u_controller (
    .i_inst (d_inst),
    .o_ctrl (d_ctrl)
  );

  hazard_unit u_hazard_unit (
    .i_view (view),
    .o_hz   (hz)
  );

endmodule

// ==== design/datapath.sv ====
`timescale 1ns/100ps

module datapath (
  input  logic                   clk,
  input  logic                   i_reset,
  input  logic [31:0]            i_inst,
  input  logic [31:0]            i_dmem_rdata,
  input  core_pkg::ctrl_t        i_ctrl,
  input  core_pkg::hazard_ctrl_t i_hz,
  output logic [31:0]            o_pc,
  output logic [31:0]            o_d_inst,
  output core_pkg::dmem_req_t    o_dmem,
  output core_pkg::hazard_view_t o_view,
  output logic                   o_retire
);
  import core_pkg::*;

  typedef struct packed {
    logic        valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] pc4;
  } if_id_t;

  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    logic [31:0] pc4;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] imm;
    logic [31:0] pc_imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
  } id_ex_t;

  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    logic [31:0] alu;
    logic [31:0] wdata;
    logic [31:0] pc4;
    logic [4:0]  rd;
  } ex_mem_t;

  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    logic [31:0] result;
    logic [31:0] rdata;
    logic [4:0]  rd;
  } mem_wb_t;

  if_id_t      if_id;
  id_ex_t      id_ex;
  ex_mem_t     ex_mem;
  mem_wb_t     mem_wb;
  logic [31:0] pc_plus4;
  logic [31:0] pc_next;
  logic [4:0]  d_rs1;
  logic [31:0] d_rdata1;
  logic [31:0] d_rdata2;
  logic [31:0] d_imm;
  logic [31:0] d_pc_imm;
  logic        d_jump;
  logic [31:0] e_src_a;
  logic [31:0] e_src_b;
  logic [31:0] e_alu_out;
  logic        e_zero;
  logic        e_taken;
  logic [31:0] m_result;
  logic [31:0] w_result;
  logic        w_reg_write;

  function automatic logic [31:0] fwd_pick(input logic [1:0] sel, input logic [31:0] rf,
                                           input logic [31:0] m, input logic [31:0] w);
    case (sel)
      FWD_MEM: return m;
      FWD_WB:  return w;
      default: return rf;
    endcase
  endfunction

  // fetch
  // a taken branch beats a jal sitting behind it
  assign pc_plus4 = o_pc + 32'd4;
  assign pc_next  = e_taken ? id_ex.pc_imm : (d_jump ? d_pc_imm : pc_plus4);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_pc <= RESET_PC;
    end else if (!i_hz.stall_f) begin
      o_pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset || i_hz.flush_d) begin
      if_id <= '0;
    end else if (!i_hz.stall_d) begin
      if_id.valid <= 1'b1;
      if_id.inst  <= i_inst;
      if_id.pc    <= o_pc;
      if_id.pc4   <= pc_plus4;
    end
  end

  // decode
  assign o_d_inst = if_id.inst;
  assign d_jump   = if_id.valid && i_ctrl.jump;
  // lui and jal read x0 so execute sees a zero operand
  assign d_rs1    = ((i_ctrl.imm_kind == imm_u) || (i_ctrl.imm_kind == imm_j)) ?
                    5'd0 : if_id.inst[19:15];
  assign d_pc_imm = if_id.pc + d_imm;

  always_comb begin
    case (i_ctrl.imm_kind)
      imm_s:   d_imm = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
      imm_b:   d_imm = {{20{if_id.inst[31]}}, if_id.inst[7], if_id.inst[30:25],
                        if_id.inst[11:8], 1'b0};
      imm_u:   d_imm = {if_id.inst[31:12], 12'b0};
      imm_j:   d_imm = {{12{if_id.inst[31]}}, if_id.inst[19:12], if_id.inst[20],
                        if_id.inst[30:21], 1'b0};
      default: d_imm = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
    endcase
  end

  reg_file u_reg_file (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_we     (w_reg_write),
    .i_waddr  (mem_wb.rd),
    .i_wdata  (w_result),
    .i_raddr1 (d_rs1),
    .i_raddr2 (if_id.inst[24:20]),
    .o_rdata1 (d_rdata1),
    .o_rdata2 (d_rdata2)
  );

  always_ff @(posedge clk) begin
    if (i_reset || i_hz.flush_e || !if_id.valid) begin
      id_ex <= '0;
    end else begin
      id_ex.valid  <= 1'b1;
      id_ex.ctrl   <= i_ctrl;
      id_ex.pc4    <= if_id.pc4;
      id_ex.rd1    <= d_rdata1;
      id_ex.rd2    <= d_rdata2;
      id_ex.imm    <= d_imm;
      id_ex.pc_imm <= d_pc_imm;
      id_ex.rs1    <= d_rs1;
      id_ex.rs2    <= if_id.inst[24:20];
      id_ex.rd     <= if_id.inst[11:7];
    end
  end

  // execute
  assign e_src_a = fwd_pick(i_hz.fwd_a, id_ex.rd1, m_result, w_result);
  assign e_src_b = fwd_pick(i_hz.fwd_b, id_ex.rd2, m_result, w_result);
  assign e_taken = id_ex.valid && id_ex.ctrl.branch && (e_zero ^ id_ex.ctrl.branch_ne);

  alu u_alu (
    .i_op     (id_ex.ctrl.alu_op),
    .i_a      (e_src_a),
    .i_b      (id_ex.ctrl.alu_src_imm ? id_ex.imm : e_src_b),
    .o_result (e_alu_out),
    .o_zero   (e_zero)
  );

  always_ff @(posedge clk) begin
    if (i_reset) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid <= id_ex.valid;
      ex_mem.ctrl  <= id_ex.ctrl;
      ex_mem.alu   <= e_alu_out;
      ex_mem.wdata <= e_src_b;
      ex_mem.pc4   <= id_ex.pc4;
      ex_mem.rd    <= id_ex.rd;
    end
  end

  // memory
  assign m_result     = (ex_mem.ctrl.result_src == res_pc4) ? ex_mem.pc4 : ex_mem.alu;
  assign o_dmem.addr  = ex_mem.alu;
  assign o_dmem.wdata = ex_mem.wdata;
  assign o_dmem.we    = ex_mem.valid && ex_mem.ctrl.mem_write;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      mem_wb <= '0;
    end else begin
      mem_wb.valid  <= ex_mem.valid;
      mem_wb.ctrl   <= ex_mem.ctrl;
      mem_wb.result <= m_result;
      mem_wb.rdata  <= i_dmem_rdata;
      mem_wb.rd     <= ex_mem.rd;
    end
  end

  // writeback
  assign w_result    = (mem_wb.ctrl.result_src == res_mem) ? mem_wb.rdata : mem_wb.result;
  assign w_reg_write = mem_wb.valid && mem_wb.ctrl.reg_write;
  assign o_retire    = mem_wb.valid;

  always_comb begin
    o_view.d_rs1          = d_rs1;
    o_view.d_rs2          = if_id.inst[24:20];
    o_view.d_jump         = d_jump;
    o_view.d_use_rs2      = if_id.valid && i_ctrl.use_rs2;
    o_view.e_rs1          = id_ex.rs1;
    o_view.e_rs2          = id_ex.rs2;
    o_view.e_rd           = id_ex.rd;
    o_view.e_mem_read     = id_ex.ctrl.mem_read;
    o_view.e_branch_taken = e_taken;
    o_view.m_rd           = ex_mem.rd;
    o_view.m_reg_write    = ex_mem.valid && ex_mem.ctrl.reg_write;
    o_view.w_rd           = mem_wb.rd;
    o_view.w_reg_write    = w_reg_write;
  end

endmodule

// ==== design/hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit (
  input  core_pkg::hazard_view_t i_view,
  output core_pkg::hazard_ctrl_t o_hz
);
  import core_pkg::*;

  logic lw_stall;

  // memory stage holds the newer value, so it wins
  function automatic logic [1:0] fwd_sel(input hazard_view_t v, input logic [4:0] rs);
    if (rs == 5'd0) return FWD_NONE;
    if (v.m_reg_write && (v.m_rd == rs)) return FWD_MEM;
    if (v.w_reg_write && (v.w_rd == rs)) return FWD_WB;
    return FWD_NONE;
  endfunction

  // load in execute feeding the instruction in decode
  assign lw_stall = i_view.e_mem_read && (i_view.e_rd != 5'd0) &&
                    ((i_view.e_rd == i_view.d_rs1) ||
                     (i_view.d_use_rs2 && (i_view.e_rd == i_view.d_rs2)));

  always_comb begin
    o_hz.fwd_a   = fwd_sel(i_view, i_view.e_rs1);
    o_hz.fwd_b   = fwd_sel(i_view, i_view.e_rs2);
    o_hz.stall_f = lw_stall;
    o_hz.stall_d = lw_stall;
    // jal redirects from decode, branches from execute
    o_hz.flush_d = i_view.d_jump || i_view.e_branch_taken;
    o_hz.flush_e = lw_stall || i_view.e_branch_taken;
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic        clk,
  input  logic        i_reset,
  input  logic        i_we,
  input  logic [4:0]  i_waddr,
  input  logic [31:0] i_wdata,
  input  logic [4:0]  i_raddr1,
  input  logic [4:0]  i_raddr2,
  output logic [31:0] o_rdata1,
  output logic [31:0] o_rdata2
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  function automatic logic [31:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0) return 32'd0;
    // same-cycle write goes straight to the reader
    if (i_we && (i_waddr == addr)) return i_wdata;
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (i_we && (i_waddr != 5'd0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  always_comb begin
    o_rdata1 = read_port(i_raddr1);
    o_rdata2 = read_port(i_raddr2);
  end

endmodule

// ==== list.f ====
design/core_pkg.sv
design/alu.sv
design/reg_file.sv
design/controller.sv
design/hazard_unit.sv
design/datapath.sv
design/core_top.sv
tests/core_checker.sv
tests/tb_core.sv

// ==== tests/core_checker.sv ====
`timescale 1ns/100ps

module core_checker (
  input  logic                clk,
  input  logic                i_reset,
  input  logic [31:0]         i_pc,
  input  core_pkg::dmem_req_t i_dmem,
  input  logic                i_retire,
  input  logic [31:0]         i_end_pc,
  input  logic [31:0]         i_exp_addr [64],
  input  logic [31:0]         i_exp_data [64],
  input  int                  i_exp_stores,
  input  int                  i_exp_retires,
  output logic                o_done,
  output int                  o_errors
);
  import core_pkg::*;

  logic prev_reset = 1'b0;
  int   mon_errors = 0;
  int   end_errors = 0;
  int   store_cnt  = 0;
  int   retire_cnt = 0;
  int   cycles;

  assign o_errors = mon_errors + end_errors;

  always @(posedge clk) begin
    if (i_reset) begin
      if (prev_reset && (i_dmem.we || i_retire)) begin
        $display("FAILED t=%0t: store enable or retire high during reset", $time);
        mon_errors++;
      end
    end else begin
      // first cycle out of reset
      if (prev_reset) begin
        if (i_pc !== RESET_PC) begin
          $display("FAILED t=%0t: pc after reset expected %h, got %h", $time, RESET_PC, i_pc);
          mon_errors++;
        end
        if (i_dmem.we || i_retire) begin
          $display("FAILED t=%0t: store enable or retire high right after reset", $time);
          mon_errors++;
        end
      end
      if (i_retire) begin
        retire_cnt++;
      end
      if (i_dmem.we) begin
        if (store_cnt >= i_exp_stores) begin
          $display("FAILED t=%0t: unexpected store [%h]=%h", $time, i_dmem.addr, i_dmem.wdata);
          mon_errors++;
        end else if ((i_dmem.addr !== i_exp_addr[store_cnt]) ||
                     (i_dmem.wdata !== i_exp_data[store_cnt])) begin
          $display("FAILED t=%0t: store %0d expected [%h]=%h, got [%h]=%h", $time, store_cnt,
                   i_exp_addr[store_cnt], i_exp_data[store_cnt], i_dmem.addr, i_dmem.wdata);
          mon_errors++;
        end
        store_cnt++;
      end
    end
    prev_reset = i_reset;
  end

  initial begin
    o_done = 1'b0;
    cycles = 0;
    @(posedge clk);
    while ((i_reset !== 1'b0) && (cycles < 100)) begin
      @(posedge clk);
      cycles++;
    end
    if (i_reset !== 1'b0) begin
      $display("reset was never released");
      end_errors++;
    end else begin
      cycles = 0;
      while ((i_pc !== i_end_pc) && (cycles < 2000)) begin
        @(posedge clk);
        cycles++;
      end
      if (i_pc !== i_end_pc) begin
        $display("timeout: program did not finish within 2000 cycles");
        end_errors++;
      end else begin
        // the final jump reaches writeback four registers after fetch
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (store_cnt != i_exp_stores) begin
          $display("FAILED t=%0t: store count expected %0d, got %0d",
                   $time, i_exp_stores, store_cnt);
          end_errors++;
        end
        if (retire_cnt != i_exp_retires) begin
          $display("FAILED t=%0t: retire count expected %0d, got %0d",
                   $time, i_exp_retires, retire_cnt);
          end_errors++;
        end
      end
    end
    o_done = 1'b1;
  end

endmodule

// ==== tests/tb_core.sv ====
`timescale 1ns/100ps

module tb_core;
  import core_pkg::*;

  localparam int          IMEM_WORDS  = 256;
  localparam int          DMEM_WORDS  = 1024;
  localparam int          MAX_STORES  = 64;
  localparam int          N_ALU       = 24;
  localparam logic [31:0] STORE_BASE  = 32'h0000_0400;
  localparam logic [31:0] LOAD_BASE   = 32'h0000_0100;
  localparam logic [11:0] POISON_ADDR = 12'h7f0;
  localparam logic [6:0]  OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0]  OPC_LOAD    = 7'b0000011;

  logic        clk;
  logic        i_reset;
  logic [31:0] pc;
  logic [31:0] inst;
  logic [31:0] dmem_rdata;
  dmem_req_t   dmem_req;
  logic        retire;
  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  int          prog_len;
  int          next_store;
  logic [31:0] end_pc;
  logic [31:0] exp_addr [MAX_STORES];
  logic [31:0] exp_data [MAX_STORES];
  int          exp_stores;
  int          exp_retires;
  logic        chk_done;
  int          chk_errors;
  int          cycles;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // both memories answer in the same cycle
  assign inst       = imem[pc[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[11:2]];

  always @(posedge clk) begin
    if (dmem_req.we) begin
      dmem[dmem_req.addr[11:2]] <= dmem_req.wdata;
    end
  end

  core_top u_core_top (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_inst       (inst),
    .i_dmem_rdata (dmem_rdata),
    .o_pc         (pc),
    .o_dmem       (dmem_req),
    .o_retire     (retire)
  );

  core_checker u_core_checker (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_pc          (pc),
    .i_dmem        (dmem_req),
    .i_retire      (retire),
    .i_end_pc      (end_pc),
    .i_exp_addr    (exp_addr),
    .i_exp_data    (exp_data),
    .i_exp_stores  (exp_stores),
    .i_exp_retires (exp_retires),
    .o_done        (chk_done),
    .o_errors      (chk_errors)
  );

  // initial data memory contents differ at every address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic is_ne);
    return {off[12], off[10:5], rs2, rs1, 2'b00, is_ne, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic store_result(input logic [4:0] rd);
    emit(s_type(STORE_BASE[11:0] + 12'(next_store * 4), rd, 5'd0));
    next_store++;
  endtask

  // a stray store and a corruption of x20 that must never execute
  task automatic poison_pair();
    emit(s_type(POISON_ADDR, 5'd1, 5'd0));
    emit(i_type(12'h7ff, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
  endtask

  task automatic build_program();
    logic [31:0] val;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prev;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    prog_len   = 0;
    next_store = 0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = 32'h0000_0013;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] <= fill_word(32'(i) << 2);
    end
    // random values in x1..x8
    for (int r = 1; r <= 8; r++) begin
      val = $urandom();
      emit({val[31:12], 5'(r), 7'b0110111});
      emit(i_type(val[11:0], 5'(r), 3'b000, 5'(r), OPC_OP_IMM));
    end
    prev = 5'd1;
    // every funct3 three times, register forms first and then immediates
    for (int n = 0; n < N_ALU; n++) begin
      rd  = 5'(9 + ($urandom() % 7));
      rs1 = ($urandom() % 2 == 0) ? prev : 5'(1 + ($urandom() % 15));
      rs2 = 5'(1 + ($urandom() % 15));
      f3  = 3'(n);
      if (n < 16) begin
        // the second pass brings in sub and sra
        alt = (n >= 8) && ((f3 == 3'b000) || (f3 == 3'b101));
        emit(r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd));
      end else begin
        imm = 12'($urandom());
        // shift immediates keep funct7 in the upper bits
        if (f3 == 3'b001) imm[11:5] = 7'b0;
        if (f3 == 3'b101) imm[11:5] = {1'b0, imm[10], 5'b0};
        emit(i_type(imm, rs1, f3, rd, OPC_OP_IMM));
      end
      store_result(rd);
      prev = rd;
    end
    // load-use pairs on rs1 and then on rs2
    emit(i_type(LOAD_BASE[11:0] + 12'h008, 5'd0, 3'b010, 5'd16, OPC_LOAD));
    emit(i_type(12'h05a, 5'd16, 3'b000, 5'd17, OPC_OP_IMM));
    store_result(5'd17);
    emit(i_type(LOAD_BASE[11:0] + 12'h024, 5'd0, 3'b010, 5'd18, OPC_LOAD));
    emit(r_type(7'b0, 5'd18, 5'd3, 3'b000, 5'd19));
    store_result(5'd19);
    // beq taken on freshly written operands, then bne not taken
    emit(i_type(12'h033, 5'd0, 3'b000, 5'd21, OPC_OP_IMM));
    emit(i_type(12'h033, 5'd0, 3'b000, 5'd22, OPC_OP_IMM));
    emit(b_type(13'd12, 5'd22, 5'd21, 1'b0));
    poison_pair();
    emit(b_type(13'd12, 5'd22, 5'd21, 1'b1));
    emit(i_type(12'h001, 5'd0, 3'b000, 5'd20, OPC_OP_IMM));
    emit(i_type(12'h002, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
    store_result(5'd20);
    // bne taken, beq not taken
    emit(b_type(13'd12, 5'd2, 5'd1, 1'b1));
    poison_pair();
    emit(b_type(13'd8, 5'd2, 5'd1, 1'b0));
    emit(i_type(12'h004, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
    store_result(5'd20);
    emit(j_type(21'd12, 5'd23));
    poison_pair();
    store_result(5'd23);
    // x0 must stay zero
    emit(i_type(12'h123, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
    store_result(5'd0);
    end_pc = RESET_PC + 32'(prog_len * 4);
    emit(j_type(21'd0, 5'd0));
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? (a - b) : (a + b);
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : (a >> b[4:0]);
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // plain instruction-set interpreter over imem
  function automatic void ref_run();
    logic [31:0] regs [32];
    logic [31:0] mem [DMEM_WORDS];
    logic [31:0] rpc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [31:0] addr;
    logic        wr;
    logic        halt;
    int          steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = 32'd0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem[i] = fill_word(32'(i) << 2);
    end
    for (int i = 0; i < MAX_STORES; i++) begin
      exp_addr[i] = 32'd0;
      exp_data[i] = 32'd0;
    end
    rpc         = RESET_PC;
    exp_stores  = 0;
    exp_retires = 0;
    halt        = 1'b0;
    steps       = 0;
    while (!halt && (steps < 1000)) begin
      w   = imem[rpc[9:2]];
      a   = regs[w[19:15]];
      b   = regs[w[24:20]];
      res = 32'd0;
      wr  = 1'b0;
      exp_retires++;
      steps++;
      case (w[6:0])
        7'b0110011: begin
          res = alu_ref(w[14:12], w[30], a, b);
          wr  = 1'b1;
          rpc = rpc + 32'd4;
        end
        7'b0010011: begin
          imm = {{20{w[31]}}, w[31:20]};
          res = alu_ref(w[14:12], (w[14:12] == 3'b101) && w[30], a, imm);
          wr  = 1'b1;
          rpc = rpc + 32'd4;
        end
        7'b0110111: begin
          res = {w[31:12], 12'b0};
          wr  = 1'b1;
          rpc = rpc + 32'd4;
        end
        7'b0000011: begin
          addr = a + {{20{w[31]}}, w[31:20]};
          res  = mem[addr[11:2]];
          wr   = 1'b1;
          rpc  = rpc + 32'd4;
        end
        7'b0100011: begin
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          mem[addr[11:2]] = b;
          if (exp_stores < MAX_STORES) begin
            exp_addr[exp_stores] = addr;
            exp_data[exp_stores] = b;
          end
          exp_stores++;
          rpc = rpc + 32'd4;
        end
        7'b1100011: begin
          imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
          rpc = ((a == b) != w[12]) ? (rpc + imm) : (rpc + 32'd4);
        end
        7'b1101111: begin
          imm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
          res  = rpc + 32'd4;
          wr   = 1'b1;
          halt = (imm == 32'd0);
          rpc  = rpc + imm;
        end
        default: rpc = rpc + 32'd4;
      endcase
      if (wr && (w[11:7] != 5'd0)) begin
        regs[w[11:7]] = res;
      end
    end
  endfunction

  initial begin
    void'($urandom(56888));
    i_reset <= 1'b1;
    build_program();
    ref_run();
    repeat (16) @(posedge clk);
    i_reset <= 1'b0;
    cycles = 0;
    while (!chk_done && (cycles < 2500)) begin
      @(posedge clk);
      cycles++;
    end
    if (!chk_done) begin
      $display("timeout: checker never reported completion");
    end
    $display("errors: %0d (expected stores %0d, expected retires %0d)",
             chk_errors, exp_stores, exp_retires);
    if (chk_done && (chk_errors == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
